// ==== list.f ====
source/rvPkg.sv
source/stageIf.sv
source/regFile.sv
source/wbDecodeStage.sv
source/operandStage.sv
source/aluStage.sv
source/rvExecCore.sv
tb/rvExecCore_asserts.sv
tb/rvExecCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RV32I execution core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

if ! verilator --binary --timing --assert -f list.f --top-module rvExecCoreTb \
    -Mdir "$OBJ" -o simv; then
    echo "verilator build failed"
    exit 1
fi

if ! "./$OBJ/simv" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi

echo "pass line not found in $LOG"
exit 1

// ==== source/aluStage.sv ====
`timescale 1ns/1ns
// RV32I ALU, third pipeline stage
// combinational result feeds forwarding, registered result is the writeback bus
module aluStage
    import rvPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    stageIf.consumer operandBus,
    stageIf.producer exFwd,
    stageIf.producer wbBus
);

    operandT             cur;
    logic [XLEN-1:0]     opA;
    logic [XLEN-1:0]     opB;
    logic [SHAMT_W-1:0]  shamt;
    logic [XLEN-1:0]     aluOut;

    assign cur = operandBus.payload;
    assign opA = cur.opA;
    assign opB = cur.opB;
    // shifts only look at the low five bits
    assign shamt = opB[SHAMT_W-1:0];

    always_comb
    begin
        case (cur.op.aluOp)
            aluAdd:  aluOut = opA + opB;
            aluSub:  aluOut = opA - opB;
            aluSll:  aluOut = opA << shamt;
            aluSlt:  aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu: aluOut = {{(XLEN-1){1'b0}}, opA < opB};
            aluXor:  aluOut = opA ^ opB;
            aluSrl:  aluOut = opA >> shamt;
            aluSra:  aluOut = $unsigned($signed(opA) >>> shamt);
            aluOr:   aluOut = opA | opB;
            aluAnd:  aluOut = opA & opB;
            // LUI immediate or host read data
            aluPass: aluOut = opB;
            default: aluOut = '0;
        endcase
    end

    // result of the op now in execute, for the operand stage
    always_comb
    begin
        exFwd.valid = operandBus.valid;
        exFwd.payload.rd = cur.op.rd;
        exFwd.payload.value = aluOut;
        exFwd.payload.writesRd = cur.op.writesRd;
        exFwd.payload.isRead = cur.op.isRead;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            wbBus.valid <= 1'b0;
        else
            wbBus.valid <= exFwd.valid;
    end

    // payload held until the next valid op
    always_ff @(posedge clk)
    begin
        if (exFwd.valid)
            wbBus.payload <= exFwd.payload;
    end

endmodule

// ==== source/operandStage.sv ====
`timescale 1ns/1ns
// operand read with forwarding, second pipeline stage
// owns the register file and writes it from the writeback bus
module operandStage
    import rvPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    stageIf.consumer decodeBus,
    stageIf.consumer exFwd,
    stageIf.consumer wbBus,
    stageIf.producer operandBus
);

    logic [XLEN-1:0] rfDataA;
    logic [XLEN-1:0] rfDataB;
    logic [XLEN-1:0] valA;
    logic [XLEN-1:0] valB;
    operandT         nextOperands;

    // newest value wins, ALU result first, then writeback, then the file
    function automatic logic [XLEN-1:0] pickOperand(
        input logic [REG_ADDR_W-1:0] idx,
        input logic [XLEN-1:0]       rfVal,
        input logic                  exValid,
        input resultT                exRes,
        input logic                  wbValid,
        input resultT                wbRes
    );
        logic [XLEN-1:0] sel;
        if (exValid && exRes.writesRd && exRes.rd == idx)
            sel = exRes.value;
        else if (wbValid && wbRes.writesRd && wbRes.rd == idx)
            sel = wbRes.value;
        else
            sel = rfVal;
        return sel;
    endfunction

    regFile regFile_i (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (decodeBus.payload.rs1),
        .readAddrB (decodeBus.payload.rs2),
        .readDataA (rfDataA),
        .readDataB (rfDataB),
        // file updated the edge after the result shows on wbBus
        .writeEn   (wbBus.valid && wbBus.payload.writesRd),
        .writeAddr (wbBus.payload.rd),
        .writeData (wbBus.payload.value)
    );

    assign valA = pickOperand(decodeBus.payload.rs1, rfDataA,
        exFwd.valid, exFwd.payload, wbBus.valid, wbBus.payload);
    assign valB = pickOperand(decodeBus.payload.rs2, rfDataB,
        exFwd.valid, exFwd.payload, wbBus.valid, wbBus.payload);

    always_comb
    begin
        nextOperands.op = decodeBus.payload;
        nextOperands.opA = valA;
        // immediate replaces rs2 for I-type and LUI
        nextOperands.opB = decodeBus.payload.useImm ? decodeBus.payload.imm : valB;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            operandBus.valid <= 1'b0;
        else
            operandBus.valid <= decodeBus.valid;
    end

    always_ff @(posedge clk)
    begin
        if (decodeBus.valid)
            operandBus.payload <= nextOperands;
    end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ns
// RV32I register file, two combinational reads and one synchronous write
// instantiated by the operand stage
module regFile
    import rvPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] readAddrA,
    input  logic [REG_ADDR_W-1:0] readAddrB,
    output logic [XLEN-1:0]       readDataA,
    output logic [XLEN-1:0]       readDataB,
    input  logic                  writeEn,
    input  logic [REG_ADDR_W-1:0] writeAddr,
    input  logic [XLEN-1:0]       writeData
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // whole file cleared on reset
    // x0 is never a write target since writesRd is dropped for rd x0
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // read ports, no clock needed
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

// ==== source/rvExecCore.sv ====
`timescale 1ns/1ns
// top of the RV32I execution pipeline with a Wishbone classic slave port
// the host writes instruction words and reads architectural registers
module rvExecCore
    import rvPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [WB_ADR_W-1:0] adr,
    input  logic [XLEN-1:0]     datIn,
    output logic [XLEN-1:0]     datOut,
    output logic                ack
);

    // decode to operand read
    stageIf #(.payloadT(decodedOpT)) decodeBus ();
    // operand read to execute
    stageIf #(.payloadT(operandT)) operandBus ();
    // combinational execute result for forwarding
    stageIf #(.payloadT(resultT)) exFwd ();
    // registered result, writeback and read response
    stageIf #(.payloadT(resultT)) wbBus ();

    wbDecodeStage wbDecodeStage_i (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .datIn     (datIn),
        .datOut    (datOut),
        .ack       (ack),
        .decodeBus (decodeBus),
        .wbBus     (wbBus)
    );

    operandStage operandStage_i (
        .clk        (clk),
        .rst        (rst),
        .decodeBus  (decodeBus),
        .exFwd      (exFwd),
        .wbBus      (wbBus),
        .operandBus (operandBus)
    );

    aluStage aluStage_i (
        .clk        (clk),
        .rst        (rst),
        .operandBus (operandBus),
        .exFwd      (exFwd),
        .wbBus      (wbBus)
    );

endmodule

// ==== source/rvPkg.sv ====
// shared widths, opcodes and pipeline payload types for the RV32I execution core
// imported by every stage module and by the top level
package rvPkg;

    // RV32I architectural sizes
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 1 << REG_ADDR_W;
    localparam int SHAMT_W = 5;

    // host word address selects a register on reads
    localparam int WB_ADR_W = 5;

    // major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    // funct7 value for SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // ten RV32I ALU functions plus pass of operand B
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd,
        aluPass
    } aluOpE;

    // one decoded operation
    typedef struct packed {
        aluOpE                 aluOp;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        logic                  useImm;
        logic                  writesRd;
        // host register read riding the pipeline
        logic                  isRead;
    } decodedOpT;

    // decoded op plus its two resolved operands
    typedef struct packed {
        decodedOpT       op;
        logic [XLEN-1:0] opA;
        logic [XLEN-1:0] opB;
    } operandT;

    // one execute result
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  writesRd;
        logic                  isRead;
    } resultT;

endpackage

// ==== source/stageIf.sv ====
`timescale 1ns/1ns
// valid plus payload link between two pipeline stages
// the payload type is set per instance, no ready since no stage stalls
interface stageIf #(
    parameter type payloadT = logic
) ();

    // payload only meaningful while valid
    logic    valid;
    payloadT payload;

    // upstream stage drives both
    modport producer (
        output valid,
        output payload
    );

    // downstream stages only look
    modport consumer (
        input valid,
        input payload
    );

endinterface

// ==== source/wbDecodeStage.sv ====
`timescale 1ns/1ns
// Wishbone classic slave and RV32I ALU decoder, first pipeline stage
// write cycles issue instructions, read cycles inject a register pass-through
module wbDecodeStage
    import rvPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [WB_ADR_W-1:0] adr,
    input  logic [XLEN-1:0]     datIn,
    output logic [XLEN-1:0]     datOut,
    output logic                ack,
    stageIf.producer            decodeBus,
    stageIf.consumer            wbBus
);

    logic       accept;
    logic       writeAck;
    logic       readPending;
    logic       readDone;
    logic       supported;
    logic       altFunct;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    decodedOpT  instrOp;
    decodedOpT  readOp;

    // funct3 to ALU function, shared by OP and OP-IMM
    function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        aluOpE sel;
        case (f3)
            3'b000: sel = alt ? aluSub : aluAdd;
            3'b001: sel = aluSll;
            3'b010: sel = aluSlt;
            3'b011: sel = aluSltu;
            3'b100: sel = aluXor;
            3'b101: sel = alt ? aluSra : aluSrl;
            3'b110: sel = aluOr;
            default: sel = aluAnd;
        endcase
        return sel;
    endfunction

    assign opcode = datIn[6:0];
    assign funct3 = datIn[14:12];
    assign funct7 = datIn[31:25];
    // bit 30 picks SUB only for OP, SRA/SRAI for both groups
    assign altFunct = funct7[5] && (opcode == OPC_OP || funct3 == 3'b101);

    // new cycle only with ack low and no read in flight
    assign accept = cyc && stb && !ack && !readPending;
    // read answered when its pass-through leaves the ALU stage
    assign readDone = wbBus.valid && wbBus.payload.isRead;
    assign ack = writeAck || readDone;
    assign datOut = wbBus.payload.value;

    always_comb
    begin
        instrOp.aluOp = aluFromFunct(funct3, altFunct);
        instrOp.rd = datIn[11:7];
        instrOp.rs1 = datIn[19:15];
        instrOp.rs2 = datIn[24:20];
        // I-type immediate, sign extended
        instrOp.imm = {{(XLEN-12){datIn[31]}}, datIn[31:20]};
        instrOp.useImm = (opcode != OPC_OP);
        instrOp.isRead = 1'b0;
        supported = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                supported = (funct7 == '0)
                    || (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM:
            begin
                supported = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101)
                begin
                    // shift amount field only
                    instrOp.imm = {{(XLEN-SHAMT_W){1'b0}}, datIn[24:20]};
                    supported = (funct7 == '0)
                        || (funct7 == FUNCT7_ALT && funct3 == 3'b101);
                end
            end
            OPC_LUI:
            begin
                instrOp.aluOp = aluPass;
                instrOp.imm = {datIn[31:12], 12'b0};
                supported = 1'b1;
            end
            default:
            begin
                // anything else becomes a no-op
                supported = 1'b0;
            end
        endcase
        instrOp.writesRd = supported && (instrOp.rd != '0);
    end

    // host read as pass of operand B, both sources point at adr
    always_comb
    begin
        readOp = '0;
        readOp.aluOp = aluPass;
        readOp.rs1 = adr;
        readOp.rs2 = adr;
        readOp.isRead = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            decodeBus.valid <= 1'b0;
            writeAck <= 1'b0;
            readPending <= 1'b0;
        end
        else
        begin
            decodeBus.valid <= accept;
            // write ack one cycle after acceptance
            writeAck <= accept && we;
            if (accept && !we)
            begin
                readPending <= 1'b1;
            end
            else if (readDone)
            begin
                readPending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            decodeBus.payload <= we ? instrOp : readOp;
        end
    end

endmodule

// ==== tb/rvExecCoreTb.sv ====
`timescale 1ns/1ns
// directed testbench for the RV32I execution core over its Wishbone slave port
// checks register reads against a reference model of RV32I semantics
module rvExecCoreTb
    import rvPkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int WRITE_ACK_CYCLES = 1;
    localparam int READ_ACK_CYCLES = 3;
    localparam int RANDOM_COUNT = 200;
    localparam logic [15:0] LFSR_SEED = 16'd10;
    // directed writes and reads rounded up on top of the random program
    localparam int WRITE_COUNT = RANDOM_COUNT + 60;
    localparam int READ_COUNT = 4 * NUM_REGS + 32;
    localparam int WATCHDOG_MARGIN = 3;
    // clock cycles per bus cycle include the drive and drop edges
    localparam int WATCHDOG_NS = (WRITE_COUNT * 4 + READ_COUNT * 6 + RESET_CYCLES)
        * WATCHDOG_MARGIN * CLK_PERIOD;

    logic                clk;
    logic                rst;
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [XLEN-1:0]     datIn;
    logic [XLEN-1:0]     datOut;
    logic                ack;
    logic [XLEN-1:0]     refRegs [NUM_REGS];
    logic [15:0]         lfsrState;

    rvExecCore rvExecCore_i (
        .clk    (clk),
        .rst    (rst),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datIn  (datIn),
        .datOut (datOut),
        .ack    (ack)
    );

    bind wbDecodeStage rvExecCore_asserts asserts_i (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .ack        (ack),
        .wbValid    (wbBus.valid),
        .wbWritesRd (wbBus.payload.writesRd),
        .wbRd       (wbBus.payload.rd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // budget derived from the issued cycle counts
    initial
    begin
        #(WATCHDOG_NS);
        abortRun("watchdog expired, the tests did not finish within their time budget");
    end

    // taps of x^16 + x^14 + x^13 + x^11 + 1
    // one step per bit
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic int randBits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            r = (r << 1) | int'(lfsrBit());
        end
        return r;
    endfunction

    // RV32I encoders
    function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] encI(input int imm, input int rs1, input int f3,
                                         input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] encShift(input int alt, input int shamt, input int rs1,
                                             input int f3, input int rd);
        logic [6:0] f7;
        f7 = (alt != 0) ? 7'h20 : 7'h00;
        return {f7, shamt[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] encLui(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    // reference ALU straight from the ISA funct3 table
    function automatic logic [XLEN-1:0] refAlu(input logic [2:0] f3, input logic alt,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
        logic [XLEN-1:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5:
            begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // architectural effect of one instruction word
    function automatic void modelExec(input logic [31:0] ins);
        logic [6:0]      opc;
        logic [6:0]      f7;
        logic [2:0]      f3;
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] res;
        logic            legal;
        opc = ins[6:0];
        f7 = ins[31:25];
        f3 = ins[14:12];
        rd = ins[11:7];
        a = refRegs[ins[19:15]];
        legal = 1'b0;
        res = '0;
        if (opc == OPC_LUI)
        begin
            legal = 1'b1;
            res = {ins[31:12], 12'h000};
        end
        else if (opc == OPC_OP)
        begin
            if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
            begin
                legal = 1'b1;
                res = refAlu(f3, f7[5], a, refRegs[ins[24:20]]);
            end
        end
        else if (opc == OPC_OP_IMM)
        begin
            if (f3 == 3'd1 || f3 == 3'd5)
            begin
                // imm[11:5] of 0x20 only legal for SRAI
                if (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5))
                begin
                    legal = 1'b1;
                    res = refAlu(f3, f7[5], a, {27'd0, ins[24:20]});
                end
            end
            else
            begin
                legal = 1'b1;
                res = refAlu(f3, 1'b0, a, {{20{ins[31]}}, ins[31:20]});
            end
        end
        if (legal && rd != 5'd0)
            refRegs[rd] = res;
    endfunction

    task automatic checkWord(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
        if (got !== exp)
            abortRun($sformatf("error at time %0t: %s is %h, expected %h",
                $time, what, got, exp));
    endtask

    // rd only means something when the result writes
    // fields shown as rd value writesRd isRead
    task automatic checkResult(input resultT got, input resultT exp);
        if (got.value !== exp.value || got.writesRd !== exp.writesRd
            || got.isRead !== exp.isRead || (exp.writesRd && got.rd !== exp.rd))
            abortRun($sformatf(
                "error at time %0t: wbBus result %0d %h %b %b, expected %0d %h %b %b",
                $time, got.rd, got.value, got.writesRd, got.isRead,
                exp.rd, exp.value, exp.writesRd, exp.isRead));
    endtask

    // wait out the acceptance edge then count cycles until ack shows up
    task automatic awaitAck(input int expected, input string kind);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        @(posedge clk);
        while (!seen && cycles < expected + 2)
        begin
            @(negedge clk);
            cycles++;
            seen = ack;
        end
        if (!seen)
            abortRun($sformatf("no ack for the %s cycle within %0d clock cycles", kind, cycles));
        else if (cycles != expected)
            abortRun($sformatf("%s ack came %0d cycles after acceptance instead of %0d",
                kind, cycles, expected));
    endtask

    task automatic wbWrite(input logic [XLEN-1:0] instr);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        adr <= '0;
        datIn <= instr;
        awaitAck(WRITE_ACK_CYCLES, "write");
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    // datOut and the wbBus payload taken while ack is high
    task automatic wbRead(input int idx, output logic [XLEN-1:0] data, output resultT res);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b0;
        adr <= idx[WB_ADR_W-1:0];
        datIn <= '0;
        awaitAck(READ_ACK_CYCLES, "read");
        data = datOut;
        res = rvExecCore_i.wbBus.payload;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic issue(input logic [XLEN-1:0] instr);
        wbWrite(instr);
        modelExec(instr);
    endtask

    task automatic readCheck(input int idx);
        logic [XLEN-1:0] data;
        resultT          res;
        resultT          expRes;
        wbRead(idx, data, res);
        // host read is a pass-through that writes nothing
        expRes.rd = '0;
        expRes.value = refRegs[idx];
        expRes.writesRd = 1'b0;
        expRes.isRead = 1'b1;
        checkWord(data, refRegs[idx], $sformatf("datOut for x%0d", idx));
        checkResult(res, expRes);
    endtask

    task automatic issueAndRead(input logic [XLEN-1:0] instr);
        issue(instr);
        readCheck(int'(instr[11:7]));
    endtask

    task automatic checkAllRegs();
        for (int i = 0; i < NUM_REGS; i++)
        begin
            readCheck(i);
        end
    endtask

    task automatic resetValuesTest();
        checkAllRegs();
    endtask

    task automatic immediateOpsTest();
        issueAndRead(encI(100, 0, 0, 1));
        issueAndRead(encI(-1, 0, 0, 2));
        issueAndRead(encI(-2048, 2, 0, 3));
        issueAndRead(encI(5, 2, 2, 4));
        // SLTIU against sign-extended all ones
        issueAndRead(encI(-1, 1, 3, 5));
        issueAndRead(encI(5, 2, 3, 6));
        issueAndRead(encI(-1, 1, 4, 7));
        issueAndRead(encI('h0F0, 1, 6, 8));
        issueAndRead(encI('h7FF, 2, 7, 9));
        issueAndRead(encShift(0, 27, 1, 1, 10));
        issueAndRead(encShift(0, 4, 2, 5, 11));
        issueAndRead(encLui('h80000, 13));
        // arithmetic shift of negative data
        issueAndRead(encShift(1, 12, 13, 5, 14));
        issueAndRead(encShift(1, 31, 2, 5, 15));
        issueAndRead(encI(-2047, 13, 0, 16));
    endtask

    task automatic regRegOpsTest();
        issue(encI(5, 0, 0, 20));
        issue(encI(7, 0, 0, 21));
        issue(encI(-3, 0, 0, 22));
        // 33 shifts by one after masking
        issue(encI(33, 0, 0, 23));
        issue(encLui('h80000, 24));
        issueAndRead(encR(0, 21, 20, 0, 25));
        issueAndRead(encR('h20, 21, 20, 0, 26));
        issueAndRead(encR(0, 23, 21, 1, 27));
        issueAndRead(encR(0, 20, 22, 2, 28));
        issueAndRead(encR(0, 20, 22, 3, 29));
        issueAndRead(encR(0, 21, 22, 4, 30));
        issueAndRead(encR(0, 23, 24, 5, 31));
        issueAndRead(encR('h20, 23, 24, 5, 1));
        issueAndRead(encR(0, 22, 20, 6, 2));
        issueAndRead(encR(0, 21, 22, 7, 3));
        issueAndRead(encR('h20, 20, 0, 0, 4));
    endtask

    // each op reads the previous result and the one before it
    task automatic dependentChainTest();
        issue(encI(3, 0, 0, 5));
        issue(encI(-4, 0, 0, 6));
        for (int k = 0; k < 10; k++)
        begin
            issue(encR((k % 2 == 1) ? 'h20 : 0, 5 + k, 6 + k, 0, 7 + k));
        end
        checkAllRegs();
    endtask

    // none of these may change any register
    task automatic discardedWritesTest();
        wbWrite(encI(55, 1, 0, 0));
        wbWrite(encR(0, 2, 1, 0, 0));
        wbWrite(encLui('h12345, 0));
        wbWrite(32'h000000EF);
        wbWrite(32'h00002083);
        wbWrite(encR('h01, 2, 1, 0, 5));
        wbWrite(encShift(1, 3, 1, 1, 6));
        wbWrite(encR('h20, 2, 1, 4, 7));
        checkAllRegs();
    endtask

    function automatic logic [31:0] randomInstr();
        int kind;
        int f3;
        int alt;
        kind = randBits(3);
        f3 = randBits(3);
        if (kind < 4)
        begin
            alt = (f3 == 0 || f3 == 5) ? randBits(1) : 0;
            return encR(alt * 32, randBits(5), randBits(5), f3, randBits(5));
        end
        else if (kind < 7)
        begin
            if (f3 == 1 || f3 == 5)
            begin
                alt = (f3 == 5) ? randBits(1) : 0;
                return encShift(alt, randBits(5), randBits(5), f3, randBits(5));
            end
            return encI(randBits(12), randBits(5), f3, randBits(5));
        end
        return encLui(randBits(20), randBits(5));
    endfunction

    task automatic randomProgramTest();
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            issue(randomInstr());
        end
        checkAllRegs();
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datIn = '0;
        lfsrState = LFSR_SEED;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            refRegs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        resetValuesTest();
        immediateOpsTest();
        regRegOpsTest();
        dependentChainTest();
        discardedWritesTest();
        randomProgramTest();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tb/rvExecCore_asserts.sv ====
`timescale 1ns/1ns
// Wishbone handshake and writeback bus checks, bound into the decode stage
module rvExecCore_asserts
    import rvPkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  cyc,
    input logic                  stb,
    input logic                  ack,
    input logic                  wbValid,
    input logic                  wbWritesRd,
    input logic [REG_ADDR_W-1:0] wbRd
);

    // ack only inside an active cycle
    ackNeedsCycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
        else $error("ack raised without cyc and stb");

    // single cycle ack pulse
    ackSinglePulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held for more than one cycle");

    // flops settle after the first reset edge
    ackQuietInReset: assert property (@(posedge clk) (rst && $past(rst)) |-> !ack)
        else $error("ack seen during reset");

    // x0 is never a writeback target
    noWriteToX0: assert property (@(posedge clk) disable iff (rst)
        (wbValid && wbWritesRd) |-> (wbRd != '0))
        else $error("writeback targets x0");

endmodule
